// File: logic/if_pkg.sv
package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Data and address width of the core
  localparam int xlen = 32;

  // Upper bits of the trap vector base from the CSR block
  localparam int mtvec_base_width = 25;

  // Interrupt index used for vectored trap entry
  localparam int irq_index_width = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch depth
  ////////////////////////////////////////////////////////////////////////////

  // Words in flight on the bus plus words held in the fetch buffer
  localparam int fetch_depth = 3;

  // Wide enough to hold 0 up to fetch_depth
  localparam int fetch_cnt_width = 2;

  ////////////////////////////////////////////////////////////////////////////
  // PC source and reset values
  ////////////////////////////////////////////////////////////////////////////

  // Source of the next fetch address on a redirect
  typedef enum logic [3:0] {
    pc_boot     = 4'd0,
    pc_jump     = 4'd1,
    pc_branch   = 4'd2,
    pc_mret     = 4'd3,
    pc_trap_exc = 4'd4,
    pc_trap_irq = 4'd5,
    pc_trap_dbg = 4'd6
  } pc_src_e;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

endpackage

// File: logic/fetch_entry_if.sv
`timescale 1ns/1ps

// Fetched words from the prefetcher into the fetch buffer
interface fetch_entry_if;

  // Push strobe, no ready since space is guaranteed by credit
  logic                                valid;
  logic [if_pkg::xlen-1:0]             addr;
  logic [if_pkg::xlen-1:0]             rdata;
  logic                                err;
  // Redirect empties the buffer
  logic                                flush;
  // Free slots reported back to the prefetcher
  logic [if_pkg::fetch_cnt_width-1:0]  free_cnt;

  modport producer (output valid, addr, rdata, err, flush, input free_cnt);

  modport consumer (input valid, addr, rdata, err, flush, output free_cnt);

endinterface

// File: logic/pc_select.sv
`timescale 1ns/1ps

module pc_select (
  input  if_pkg::pc_src_e                      pc_src_i,
  input  logic [if_pkg::xlen-1:0]              boot_addr_i,
  input  logic [if_pkg::xlen-1:0]              jump_target_i,
  input  logic [if_pkg::xlen-1:0]              branch_target_i,
  input  logic [if_pkg::xlen-1:0]              mepc_i,
  input  logic [if_pkg::xlen-1:0]              dm_halt_addr_i,
  input  logic [if_pkg::mtvec_base_width-1:0]  mtvec_addr_i,
  input  logic [if_pkg::irq_index_width-1:0]   irq_index_i,
  output logic [if_pkg::xlen-1:0]              target_o
);

  // Redirect target mux
  // Every target leaves here word aligned
  always_comb begin
    target_o = {boot_addr_i[if_pkg::xlen-1:2], 2'b00};
    case (pc_src_i)
      if_pkg::pc_boot: begin
        target_o = {boot_addr_i[if_pkg::xlen-1:2], 2'b00};
      end
      if_pkg::pc_jump: begin
        target_o = {jump_target_i[if_pkg::xlen-1:2], 2'b00};
      end
      if_pkg::pc_branch: begin
        target_o = {branch_target_i[if_pkg::xlen-1:2], 2'b00};
      end
      // Return from trap restores mepc
      if_pkg::pc_mret: begin
        target_o = {mepc_i[if_pkg::xlen-1:2], 2'b00};
      end
      // All exceptions enter at the vector base
      if_pkg::pc_trap_exc: begin
        target_o = {mtvec_addr_i, 7'h00};
      end
      // Interrupts are vectored by index
      if_pkg::pc_trap_irq: begin
        target_o = {mtvec_addr_i, irq_index_i, 2'b00};
      end
      if_pkg::pc_trap_dbg: begin
        target_o = {dm_halt_addr_i[if_pkg::xlen-1:2], 2'b00};
      end
      default: begin
        target_o = {boot_addr_i[if_pkg::xlen-1:2], 2'b00};
      end
    endcase
  end

endmodule

// File: logic/prefetch_unit.sv
`timescale 1ns/1ps

module prefetch_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pc_set_i,
  input  logic [if_pkg::xlen-1:0]  target_i,
  output logic                     instr_req_o,
  output logic [if_pkg::xlen-1:0]  instr_addr_o,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic [if_pkg::xlen-1:0]  instr_rdata_i,
  input  logic                     instr_err_i,
  fetch_entry_if.producer          fetch,
  output logic                     busy_o
);

  // Fetching starts with the first redirect
  logic                                active_q;
  // Address on the bus, or the next one to request
  logic [if_pkg::xlen-1:0]             addr_q;
  // Redirect waiting behind a request that is not yet granted
  logic                                redir_pend_q;
  logic [if_pkg::xlen-1:0]             redir_addr_q;
  // Granted requests without response
  logic [if_pkg::fetch_cnt_width-1:0]  out_cnt_q;
  logic [if_pkg::fetch_cnt_width-1:0]  out_cnt_n;
  // Stale responses still to drop
  logic [if_pkg::fetch_cnt_width-1:0]  discard_q;
  logic [if_pkg::fetch_cnt_width-1:0]  discard_n;
  // Address queue for granted requests
  logic [if_pkg::xlen-1:0]             addr_queue [if_pkg::fetch_depth];
  logic [if_pkg::fetch_cnt_width-1:0]  wr_ptr_q;
  logic [if_pkg::fetch_cnt_width-1:0]  rd_ptr_q;
  logic                                gnt_acc;
  logic                                req_hold;
  logic                                stale_resp;

  ////////////////////////////////////////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////////////////////////////////////////

  // Credit check keeps outstanding plus buffered words within the depth
  // A held request stays up on its own since credit never shrinks meanwhile
  assign instr_req_o  = active_q && (redir_pend_q || (out_cnt_q < fetch.free_cnt));
  assign instr_addr_o = addr_q;
  assign gnt_acc      = instr_req_o && instr_gnt_i;
  // Request is committed to the bus for the next cycle
  assign req_hold     = instr_req_o && !instr_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      addr_q       <= '0;
      redir_pend_q <= 1'b0;
      redir_addr_q <= '0;
    end else if (pc_set_i) begin
      active_q <= 1'b1;
      if (req_hold) begin
        // Old request finishes first, then the target goes out
        redir_pend_q <= 1'b1;
        redir_addr_q <= target_i;
      end else begin
        redir_pend_q <= 1'b0;
        addr_q       <= target_i;
      end
    end else if (gnt_acc) begin
      if (redir_pend_q) begin
        redir_pend_q <= 1'b0;
        addr_q       <= redir_addr_q;
      end else begin
        // Sequential word fetch
        addr_q <= addr_q + if_pkg::xlen'(4);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding and discard counters
  ////////////////////////////////////////////////////////////////////////////

  assign stale_resp = (discard_q != '0);
  assign out_cnt_n  = out_cnt_q + if_pkg::fetch_cnt_width'(gnt_acc)
                      - if_pkg::fetch_cnt_width'(instr_rvalid_i);

  always_comb begin
    discard_n = discard_q;
    if (pc_set_i) begin
      // Everything granted so far is stale
      discard_n = out_cnt_n;
    end else begin
      if (instr_rvalid_i && stale_resp) begin
        discard_n = discard_n - if_pkg::fetch_cnt_width'(1);
      end
      // Held request granted after its redirect
      if (gnt_acc && redir_pend_q) begin
        discard_n = discard_n + if_pkg::fetch_cnt_width'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q <= '0;
      discard_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end else begin
      out_cnt_q <= out_cnt_n;
      discard_q <= discard_n;
      if (gnt_acc) begin
        wr_ptr_q <= (wr_ptr_q == if_pkg::fetch_cnt_width'(if_pkg::fetch_depth - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      // Every response pops, kept or dropped
      if (instr_rvalid_i) begin
        rd_ptr_q <= (rd_ptr_q == if_pkg::fetch_cnt_width'(if_pkg::fetch_depth - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_acc) begin
      addr_queue[wr_ptr_q] <= addr_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Push into fetch buffer
  ////////////////////////////////////////////////////////////////////////////

  // Response in a redirect cycle is stale too
  assign fetch.valid = instr_rvalid_i && !stale_resp && !pc_set_i;
  assign fetch.addr  = addr_queue[rd_ptr_q];
  assign fetch.rdata = instr_rdata_i;
  assign fetch.err   = instr_err_i;
  assign fetch.flush = pc_set_i;

  assign busy_o = (out_cnt_q != '0);

  // Outstanding plus buffered words stay within the depth
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    int'(out_cnt_q) + if_pkg::fetch_depth - int'(fetch.free_cnt) <= if_pkg::fetch_depth);

  // Bus request holds until granted
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_hold |=> instr_req_o && $stable(instr_addr_o));

endmodule

// File: logic/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer (
  input  logic                     clk,
  input  logic                     rst_n,
  fetch_entry_if.consumer          fetch,
  input  logic                     halt_i,
  output logic                     valid_o,
  output logic [if_pkg::xlen-1:0]  addr_o,
  output logic [if_pkg::xlen-1:0]  rdata_o,
  output logic                     err_o,
  input  logic                     ready_i
);

  // Entry storage
  logic [if_pkg::xlen-1:0]             addr_mem [if_pkg::fetch_depth];
  logic [if_pkg::xlen-1:0]             data_mem [if_pkg::fetch_depth];
  logic [if_pkg::fetch_depth-1:0]      err_mem;
  logic [if_pkg::fetch_cnt_width-1:0]  wr_ptr_q;
  logic [if_pkg::fetch_cnt_width-1:0]  rd_ptr_q;
  logic [if_pkg::fetch_cnt_width-1:0]  count_q;
  logic                                push;
  logic                                pop;

  // Flush wins over a push in the same cycle
  assign push = fetch.valid && !fetch.flush;
  assign pop  = valid_o && ready_i;

  assign fetch.free_cnt = if_pkg::fetch_cnt_width'(if_pkg::fetch_depth) - count_q;

  // Head entry, nothing leaves while halted
  assign valid_o = (count_q != '0) && !halt_i;
  assign addr_o  = addr_mem[rd_ptr_q];
  assign rdata_o = data_mem[rd_ptr_q];
  assign err_o   = err_mem[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (fetch.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == if_pkg::fetch_cnt_width'(if_pkg::fetch_depth - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == if_pkg::fetch_cnt_width'(if_pkg::fetch_depth - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + if_pkg::fetch_cnt_width'(push) - if_pkg::fetch_cnt_width'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr_q] <= fetch.addr;
      data_mem[wr_ptr_q] <= fetch.rdata;
      err_mem[wr_ptr_q]  <= fetch.err;
    end
  end

  // Prefetcher credit must keep a slot free for every push
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> count_q != if_pkg::fetch_cnt_width'(if_pkg::fetch_depth));

endmodule

// File: logic/if_id_register.sv
`timescale 1ns/1ps

module if_id_register (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid_i,
  input  logic [if_pkg::xlen-1:0]  addr_i,
  input  logic [if_pkg::xlen-1:0]  rdata_i,
  input  logic                     err_i,
  output logic                     ready_o,
  input  logic                     id_ready_i,
  output logic                     id_valid_o,
  output logic [if_pkg::xlen-1:0]  id_instr_o,
  output logic [if_pkg::xlen-1:0]  id_pc_o,
  output logic                     id_bus_err_o,
  output logic                     id_abort_o
);

  // Abort reasons, only the bus error for now
  logic abort_n;

  assign abort_n = err_i;

  // Take a word only when decode can accept
  assign ready_o = id_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o   <= 1'b0;
      id_instr_o   <= if_pkg::nop_instr;
      id_pc_o      <= '0;
      id_bus_err_o <= 1'b0;
      id_abort_o   <= 1'b0;
    end else if (id_ready_i) begin
      if (valid_i) begin
        id_valid_o   <= 1'b1;
        id_instr_o   <= rdata_i;
        id_pc_o      <= addr_i;
        id_bus_err_o <= err_i;
        id_abort_o   <= abort_n;
      end else begin
        // Bubble into decode
        id_valid_o <= 1'b0;
      end
    end
  end

  // Decode sees a frozen word while it stalls
  a_hold_stall: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_o && !id_ready_i |=>
      $stable({id_valid_o, id_instr_o, id_pc_o, id_bus_err_o, id_abort_o}));

endmodule

// File: logic/if_stage.sv
`timescale 1ns/1ps

module if_stage (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // Redirect targets
  input  logic [if_pkg::xlen-1:0]              boot_addr_i,
  input  logic [if_pkg::xlen-1:0]              jump_target_i,
  input  logic [if_pkg::xlen-1:0]              branch_target_i,
  input  logic [if_pkg::xlen-1:0]              mepc_i,
  input  logic [if_pkg::mtvec_base_width-1:0]  mtvec_addr_i,
  input  logic [if_pkg::irq_index_width-1:0]   irq_index_i,
  input  logic [if_pkg::xlen-1:0]              dm_halt_addr_i,

  // Controller
  input  logic                                 pc_set_i,
  input  if_pkg::pc_src_e                      pc_src_i,
  input  logic                                 halt_if_i,

  // Instruction bus
  output logic                                 instr_req_o,
  output logic [if_pkg::xlen-1:0]              instr_addr_o,
  input  logic                                 instr_gnt_i,
  input  logic                                 instr_rvalid_i,
  input  logic [if_pkg::xlen-1:0]              instr_rdata_i,
  input  logic                                 instr_err_i,

  // Decode stage
  input  logic                                 id_ready_i,
  output logic                                 id_valid_o,
  output logic [if_pkg::xlen-1:0]              id_instr_o,
  output logic [if_pkg::xlen-1:0]              id_pc_o,
  output logic                                 id_bus_err_o,
  output logic                                 id_abort_o,

  // Status
  output logic                                 if_busy_o,
  output logic                                 csr_mtvec_init_o
);

  logic [if_pkg::xlen-1:0]  target;
  logic                     buf_valid;
  logic [if_pkg::xlen-1:0]  buf_addr;
  logic [if_pkg::xlen-1:0]  buf_rdata;
  logic                     buf_err;
  logic                     buf_ready;

  // Prefetcher to buffer link
  fetch_entry_if fetch_bus ();

  // CSR block loads mtvec on boot
  assign csr_mtvec_init_o = pc_set_i && (pc_src_i == if_pkg::pc_boot);

  ////////////////////////////////////////////////////////////////////////////
  // Address select, prefetch, buffer, IF/ID
  ////////////////////////////////////////////////////////////////////////////

  pc_select pc_select_i (
    .pc_src_i        (pc_src_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .dm_halt_addr_i  (dm_halt_addr_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .irq_index_i     (irq_index_i),
    .target_o        (target)
  );

  prefetch_unit prefetch_unit_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .target_i       (target),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .fetch          (fetch_bus.producer),
    .busy_o         (if_busy_o)
  );

  fetch_buffer fetch_buffer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .fetch   (fetch_bus.consumer),
    .halt_i  (halt_if_i),
    .valid_o (buf_valid),
    .addr_o  (buf_addr),
    .rdata_o (buf_rdata),
    .err_o   (buf_err),
    .ready_i (buf_ready)
  );

  if_id_register if_id_register_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (buf_valid),
    .addr_i       (buf_addr),
    .rdata_i      (buf_rdata),
    .err_i        (buf_err),
    .ready_o      (buf_ready),
    .id_ready_i   (id_ready_i),
    .id_valid_o   (id_valid_o),
    .id_instr_o   (id_instr_o),
    .id_pc_o      (id_pc_o),
    .id_bus_err_o (id_bus_err_o),
    .id_abort_o   (id_abort_o)
  );

endmodule

// File: sim/instr_mem_model.sv
`timescale 1ns/1ps

// Instruction bus responder with random grant and response latency
module instr_mem_model (
  input  logic                     clk,
  input  logic                     req_i,
  input  logic [if_pkg::xlen-1:0]  addr_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output logic [if_pkg::xlen-1:0]  rdata_o,
  output logic                     err_o
);

  // Granted requests waiting for their response, oldest first
  logic [if_pkg::xlen-1:0]  pend_addr [$];
  int unsigned              pend_due [$];
  int unsigned              cycle;
  int unsigned              due;
  int unsigned              gnt_wait;
  logic                     wait_armed;
  logic [if_pkg::xlen-1:0]  gnt_addr;
  logic [if_pkg::xlen-1:0]  head;

  initial begin
    gnt_o      = 1'b0;
    rvalid_o   = 1'b0;
    rdata_o    = '0;
    err_o      = 1'b0;
    cycle      = 0;
    gnt_wait   = 0;
    wait_armed = 1'b0;
    gnt_addr   = '0;
  end

  // All outputs change on the falling edge, the DUT samples on the rising one
  always @(negedge clk) begin
    cycle++;
    // Grant driven last cycle was taken at the rising edge
    if (gnt_o) begin
      // Response 1 to 3 cycles after the grant, never overtaking
      due = cycle + $urandom_range(0, 2);
      if (pend_due.size() != 0 && due < pend_due[pend_due.size()-1]) begin
        due = pend_due[pend_due.size()-1];
      end
      pend_addr.push_back(gnt_addr);
      pend_due.push_back(due);
    end
    // Response driven last cycle was consumed
    if (rvalid_o) begin
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end

    // Grant after 0 to 2 cycles of a held request
    gnt_o = 1'b0;
    if (req_i) begin
      if (!wait_armed) begin
        gnt_wait   = $urandom_range(0, 2);
        wait_armed = 1'b1;
      end
      if (gnt_wait == 0) begin
        gnt_o      = 1'b1;
        wait_armed = 1'b0;
        gnt_addr   = addr_i;
      end else begin
        gnt_wait--;
      end
    end else begin
      wait_armed = 1'b0;
    end

    // Head response once its delay has run out
    if (pend_addr.size() != 0 && pend_due[0] <= cycle) begin
      head     = pend_addr[0];
      rvalid_o = 1'b1;
      rdata_o  = head ^ 32'hA5A5_0000;
      // Error window where address bits 7:4 are all ones
      err_o    = (head[7:4] == 4'hf);
    end else begin
      rvalid_o = 1'b0;
      rdata_o  = '0;
      err_o    = 1'b0;
    end
  end

endmodule

// File: sim/if_stage_tb.sv
`timescale 1ns/1ps

module if_stage_tb;

  logic                                 clk;
  logic                                 rst_n;
  logic [if_pkg::xlen-1:0]              boot_addr;
  logic [if_pkg::xlen-1:0]              jump_target;
  logic [if_pkg::xlen-1:0]              branch_target;
  logic [if_pkg::xlen-1:0]              mepc;
  logic [if_pkg::mtvec_base_width-1:0]  mtvec_addr;
  logic [if_pkg::irq_index_width-1:0]   irq_index;
  logic [if_pkg::xlen-1:0]              dm_halt_addr;
  logic                                 pc_set;
  if_pkg::pc_src_e                      pc_src;
  logic                                 halt_if;
  logic                                 instr_req;
  logic [if_pkg::xlen-1:0]              instr_addr;
  logic                                 instr_gnt;
  logic                                 instr_rvalid;
  logic [if_pkg::xlen-1:0]              instr_rdata;
  logic                                 instr_err;
  logic                                 id_ready;
  logic                                 id_valid;
  logic [if_pkg::xlen-1:0]              id_instr;
  logic [if_pkg::xlen-1:0]              id_pc;
  logic                                 id_bus_err;
  logic                                 id_abort;
  logic                                 if_busy;
  logic                                 csr_mtvec_init;

  // Reference model state
  logic [if_pkg::xlen-1:0]  exp_pc;
  logic [if_pkg::xlen-1:0]  old_exp;
  logic [if_pkg::xlen-1:0]  stale_pc;
  logic [if_pkg::xlen-1:0]  pc_ref;
  logic                     stale;
  logic                     check_stale;
  logic                     hold_pending;
  logic [if_pkg::xlen-1:0]  held_pc;
  logic [if_pkg::xlen-1:0]  held_instr;
  logic                     held_err;
  logic                     held_abort;
  logic                     random_ready;
  int                       halt_seen;
  int                       word_count;
  int                       err_words;
  int                       hold_checks;
  int                       boot_pulses;
  int                       checks;
  int                       errors;
  int                       tests;

  if_stage uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .boot_addr_i      (boot_addr),
    .jump_target_i    (jump_target),
    .branch_target_i  (branch_target),
    .mepc_i           (mepc),
    .mtvec_addr_i     (mtvec_addr),
    .irq_index_i      (irq_index),
    .dm_halt_addr_i   (dm_halt_addr),
    .pc_set_i         (pc_set),
    .pc_src_i         (pc_src),
    .halt_if_i        (halt_if),
    .instr_req_o      (instr_req),
    .instr_addr_o     (instr_addr),
    .instr_gnt_i      (instr_gnt),
    .instr_rvalid_i   (instr_rvalid),
    .instr_rdata_i    (instr_rdata),
    .instr_err_i      (instr_err),
    .id_ready_i       (id_ready),
    .id_valid_o       (id_valid),
    .id_instr_o       (id_instr),
    .id_pc_o          (id_pc),
    .id_bus_err_o     (id_bus_err),
    .id_abort_o       (id_abort),
    .if_busy_o        (if_busy),
    .csr_mtvec_init_o (csr_mtvec_init)
  );

  instr_mem_model mem (
    .clk      (clk),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata),
    .err_o    (instr_err)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  // Redirect address as the core expects it for each source
  function automatic logic [if_pkg::xlen-1:0] redirect_target(input if_pkg::pc_src_e src);
    logic [if_pkg::xlen-1:0] t;
    case (src)
      if_pkg::pc_jump:     t = jump_target & ~32'h3;
      if_pkg::pc_branch:   t = branch_target & ~32'h3;
      if_pkg::pc_mret:     t = mepc & ~32'h3;
      if_pkg::pc_trap_exc: t = {mtvec_addr, 7'b0};
      if_pkg::pc_trap_irq: t = {mtvec_addr, irq_index, 2'b00};
      if_pkg::pc_trap_dbg: t = dm_halt_addr & ~32'h3;
      default:             t = boot_addr & ~32'h3;
    endcase
    return t;
  endfunction

  // Memory contents and error window as seen from the fetch side
  function automatic logic [if_pkg::xlen-1:0] expected_instr(input logic [if_pkg::xlen-1:0] pc);
    return pc ^ 32'hA5A5_0000;
  endfunction

  function automatic logic expected_err(input logic [if_pkg::xlen-1:0] pc);
    return pc[7:4] == 4'hf;
  endfunction

  task automatic check_value(input string name, input logic [if_pkg::xlen-1:0] actual,
                             input logic [if_pkg::xlen-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor on values just before each rising edge
  ////////////////////////////////////////////////////////////////////////////

  // Word handed to decode at this edge
  task automatic take_word();
    pc_ref = stale ? stale_pc : exp_pc;
    check_value("id_pc_o", id_pc, pc_ref);
    check_value("id_instr_o", id_instr, expected_instr(pc_ref));
    check_value("id_bus_err_o", id_bus_err, expected_err(pc_ref));
    check_value("id_abort_o", id_abort, expected_err(pc_ref));
    if (stale) begin
      // Last word of the old stream that decode would kill
      stale = 1'b0;
    end else begin
      exp_pc = exp_pc + 32'd4;
      word_count++;
      if (id_bus_err) begin
        err_words++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      check_value("csr_mtvec_init_o", csr_mtvec_init, pc_set && (pc_src == if_pkg::pc_boot));
      if (csr_mtvec_init) begin
        boot_pulses++;
      end
      // A word left in IF/ID after a redirect is old since IF/ID is not flushed
      if (check_stale) begin
        check_stale = 1'b0;
        if (id_valid && !stale) begin
          stale    = 1'b1;
          stale_pc = old_exp;
        end
      end
      // Decode stall freezes the register
      if (hold_pending) begin
        check_value("id_valid_o", id_valid, 1'b1);
        check_value("id_pc_o", id_pc, held_pc);
        check_value("id_instr_o", id_instr, held_instr);
        check_value("id_bus_err_o", id_bus_err, held_err);
        check_value("id_abort_o", id_abort, held_abort);
        hold_checks++;
      end
      hold_pending = id_valid && !id_ready;
      held_pc      = id_pc;
      held_instr   = id_instr;
      held_err     = id_bus_err;
      held_abort   = id_abort;
      // Nothing reaches decode once halt has had two cycles
      if (halt_if) begin
        if (halt_seen >= 2) begin
          check_value("id_valid_o", id_valid, 1'b0);
        end
        halt_seen++;
      end else begin
        halt_seen = 0;
      end
      if (id_valid && id_ready) begin
        take_word();
      end
      if (pc_set) begin
        old_exp     = exp_pc;
        exp_pc      = redirect_target(pc_src);
        check_stale = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(negedge clk);
    pc_set   = 1'b0;
    id_ready = random_ready ? ($urandom_range(0, 2) != 0) : 1'b1;
  endtask

  task automatic redirect(input if_pkg::pc_src_e src);
    next_cycle();
    pc_src = src;
    pc_set = 1'b1;
  endtask

  task automatic randomize_targets();
    boot_addr     = $urandom();
    jump_target   = $urandom();
    branch_target = $urandom();
    mepc          = $urandom();
    mtvec_addr    = if_pkg::mtvec_base_width'($urandom());
    irq_index     = if_pkg::irq_index_width'($urandom());
    dm_halt_addr  = $urandom();
  endtask

  task automatic wait_words(input int n, input int limit, input string what);
    int target;
    int cycles;
    target = word_count + n;
    cycles = 0;
    while (word_count < target && cycles < limit) begin
      next_cycle();
      cycles++;
    end
    if (word_count < target) begin
      errors++;
      $display("Timeout at %0t ns: %s delivered only %0d of %0d words", $time, what,
               n - (target - word_count), n);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    $display("Test %s done with %0d errors", name, errors - errs_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int e0;
    int base;
    int count0;
    int halt_len;
    logic [if_pkg::xlen-1:0] region;

    void'($urandom(32'h128b));
    clk = 1'b0;
    rst_n = 1'b0;
    pc_set = 1'b0;
    pc_src = if_pkg::pc_boot;
    halt_if = 1'b0;
    id_ready = 1'b1;
    random_ready = 1'b0;
    randomize_targets();
    exp_pc = '0;
    old_exp = '0;
    stale_pc = '0;
    pc_ref = '0;
    stale = 1'b0;
    check_stale = 1'b0;
    hold_pending = 1'b0;
    held_pc = '0;
    held_instr = '0;
    held_err = 1'b0;
    held_abort = 1'b0;
    halt_seen = 0;
    word_count = 0;
    err_words = 0;
    hold_checks = 0;
    boot_pulses = 0;
    checks = 0;
    errors = 0;
    tests = 0;

    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Boot fetch after an idle start
    e0 = errors;
    repeat (3) begin
      next_cycle();
      check_value("instr_req_o", instr_req, 1'b0);
      check_value("id_valid_o", id_valid, 1'b0);
      check_value("csr_mtvec_init_o", csr_mtvec_init, 1'b0);
      check_value("if_busy_o", if_busy, 1'b0);
    end
    count0 = boot_pulses;
    redirect(if_pkg::pc_boot);
    boot_addr = $urandom();
    wait_words(12, 300, "boot fetch");
    check_value("csr_mtvec_init_o pulses", boot_pulses - count0, 1);
    end_test("boot_fetch", e0);

    // Every source with some redirects while words are in flight
    e0 = errors;
    for (int i = 0; i < 28; i++) begin
      random_ready = (i >= 14);
      repeat ($urandom_range(0, 5)) next_cycle();
      redirect(if_pkg::pc_src_e'(i % 7));
      randomize_targets();
      if ($urandom_range(0, 1) == 1) begin
        wait_words(1, 100, "redirect");
      end
    end
    random_ready = 1'b0;
    wait_words(8, 200, "redirect tail");
    end_test("redirect_targets", e0);

    // Run through an error window at bits 7:4 all ones
    e0 = errors;
    count0 = err_words;
    redirect(if_pkg::pc_jump);
    region = $urandom();
    jump_target = {region[31:8], 8'hc4};
    wait_words(24, 400, "bus error");
    check_value("id_bus_err_o words", (err_words - count0) >= 4, 1'b1);
    end_test("bus_error", e0);

    // Random decode stalls
    e0 = errors;
    count0 = hold_checks;
    random_ready = 1'b1;
    redirect(if_pkg::pc_branch);
    branch_target = $urandom();
    wait_words(40, 1000, "back-pressure");
    check_value("id_ready_i stall cycles", hold_checks != count0, 1'b1);
    random_ready = 1'b0;
    end_test("back_pressure", e0);

    // Halt holds words in the buffer and release continues the sequence
    e0 = errors;
    redirect(if_pkg::pc_mret);
    mepc = $urandom();
    wait_words(4, 200, "halt lead-in");
    next_cycle();
    halt_if = 1'b1;
    halt_len = $urandom_range(5, 10);
    base = 0;
    while (base < halt_len) begin
      next_cycle();
      base++;
    end
    halt_if = 1'b0;
    wait_words(8, 200, "halt release");
    end_test("halt", e0);

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/if_pkg.sv
logic/fetch_entry_if.sv
logic/pc_select.sv
logic/prefetch_unit.sv
logic/fetch_buffer.sv
logic/if_id_register.sv
logic/if_stage.sv
sim/instr_mem_model.sv
sim/if_stage_tb.sv
